// File: design/mipsCtrlPkg.sv
`default_nettype none

package mipsCtrlPkg;

  localparam int instrWidth = 32;

  typedef enum logic [5:0] {
    opRType  = 6'b000000,
    opRegImm = 6'b000001,
    opJ      = 6'b000010,
    opJal    = 6'b000011,
    opBeq    = 6'b000100,
    opBne    = 6'b000101,
    opBlez   = 6'b000110,
    opBgtz   = 6'b000111,
    opAddiu  = 6'b001001,
    opAndi   = 6'b001100,
    opOri    = 6'b001101,
    opXori   = 6'b001110,
    opLb     = 6'b100000,
    opLh     = 6'b100001,
    opLw     = 6'b100011,
    opLbu    = 6'b100100,
    opLhu    = 6'b100101,
    opSw     = 6'b101011
  } opcode_t;

  typedef enum logic [5:0] {
    functJr   = 6'b001000,
    functAddu = 6'b100001,
    functAnd  = 6'b100100,
    functOr   = 6'b100101
  } functCode_t;

  typedef enum logic [2:0] {
    stateFetch   = 3'b000,
    stateDecode  = 3'b001,
    stateExec1   = 3'b010,
    stateExec2   = 3'b011,
    stateExec3   = 3'b100,
    stateHalted  = 3'b101,
    stateMemWait = 3'b110
  } ctrlState_t;

  typedef enum logic [4:0] {
    aluAnd          = 5'b00000,
    aluOr           = 5'b00001,
    aluAdd          = 5'b00010,
    aluXor          = 5'b00011,
    aluSetGtz       = 5'b00111,
    aluCompareEq    = 5'b01010,
    aluPassB        = 5'b01011,
    aluSetLez       = 5'b01100,
    aluBranchTarget = 5'b01101,
    aluPassA        = 5'b01110,
    aluFunct        = 5'b01111,
    aluJumpTarget   = 5'b10001
  } aluOp_t;

  typedef enum logic [1:0] {
    srcBReg        = 2'b00,
    srcBFour       = 2'b01,
    srcBImm        = 2'b10,
    srcBImmShifted = 2'b11
  } aluSrcB_t;

  typedef enum logic [3:0] {
    classAluReg, classAluImm, classLoad, classStore, classBranch,
    classJump, classJumpLink, classJumpReg, classUnknown
  } instrClass_t;

  typedef enum logic [2:0] {
    condEq, condNe, condLez, condGtz, condLtz, condGez
  } branchCond_t;

  typedef enum logic [1:0] {
    sizeWord, sizeHalf, sizeByte
  } accessSize_t;

  // Encodings match the load data extender
  typedef enum logic [1:0] {
    extendNone     = 2'b00,
    extendSignByte = 2'b10,
    extendSignHalf = 2'b11
  } loadExtend_t;

endpackage

`default_nettype wire

// File: design/instrClassifier.sv
`timescale 1ns/100ps
`default_nettype none

module instrClassifier (
  input  wire logic [mipsCtrlPkg::instrWidth-1:0] instr,
  output mipsCtrlPkg::instrClass_t                instrClass,
  output mipsCtrlPkg::branchCond_t                branchCond,
  output mipsCtrlPkg::accessSize_t                accessSize,
  output logic                                    signedLoad,
  output mipsCtrlPkg::aluOp_t                     immAluOp
);
  import mipsCtrlPkg::*;

  // rt field values under the REGIMM opcode
  localparam logic [4:0] rtBltz = 5'b00000;
  localparam logic [4:0] rtBgez = 5'b00001;

  opcode_t    opcode;
  functCode_t funct;
  logic [4:0] rt;

  assign opcode = opcode_t'(instr[31:26]);
  assign funct  = functCode_t'(instr[5:0]);
  assign rt     = instr[20:16];

  always_comb begin
    instrClass = classUnknown;
    branchCond = condEq;
    accessSize = sizeWord;
    signedLoad = 1'b0;
    immAluOp   = aluAdd;
    case (opcode)
      opRType: begin
        case (funct)
          functAddu, functAnd, functOr: instrClass = classAluReg;
          functJr:                      instrClass = classJumpReg;
          default:                      instrClass = classUnknown;
        endcase
      end
      opRegImm: begin
        if (rt == rtBltz || rt == rtBgez) begin
          instrClass = classBranch;
          branchCond = (rt == rtBltz) ? condLtz : condGez;
        end
      end
      opBeq:  begin instrClass = classBranch; branchCond = condEq;  end
      opBne:  begin instrClass = classBranch; branchCond = condNe;  end
      opBlez: begin instrClass = classBranch; branchCond = condLez; end
      opBgtz: begin instrClass = classBranch; branchCond = condGtz; end
      opAddiu: begin instrClass = classAluImm; immAluOp = aluAdd; end
      opAndi:  begin instrClass = classAluImm; immAluOp = aluAnd; end
      opOri:   begin instrClass = classAluImm; immAluOp = aluOr;  end
      opXori:  begin instrClass = classAluImm; immAluOp = aluXor; end
      opLw:  instrClass = classLoad;
      opLh:  begin instrClass = classLoad; accessSize = sizeHalf; signedLoad = 1'b1; end
      opLhu: begin instrClass = classLoad; accessSize = sizeHalf; end
      opLb:  begin instrClass = classLoad; accessSize = sizeByte; signedLoad = 1'b1; end
      opLbu: begin instrClass = classLoad; accessSize = sizeByte; end
      opSw:  instrClass = classStore;
      opJ:   instrClass = classJump;
      opJal: instrClass = classJumpLink;
      default: instrClass = classUnknown;
    endcase
  end

endmodule

`default_nettype wire

// File: design/controlSequencer.sv
`timescale 1ns/100ps
`default_nettype none

module controlSequencer (
  input  wire logic                     clk,
  input  wire logic                     rstN,
  input  wire logic                     run,
  input  wire logic                     pcIsZero,
  input  wire logic                     waitrequest,
  input  wire logic                     stall,
  input  wire logic                     aluLsb,
  input  wire logic                     lessThan,
  input  mipsCtrlPkg::instrClass_t      instrClass,
  input  mipsCtrlPkg::branchCond_t      branchCond,
  output mipsCtrlPkg::ctrlState_t       state,
  output logic                          pcWrite,
  output logic                          irWrite,
  output logic                          pcSrc,
  output logic                          active
);
  import mipsCtrlPkg::*;

  ctrlState_t nextState;
  logic       branchDelay;
  logic       branchTaken;
  logic       needExec2;

  assign needExec2 = instrClass inside {classAluReg, classAluImm, classLoad, classStore};

  always_comb begin
    case (branchCond)
      condEq, condLez: branchTaken = aluLsb;
      condNe, condGtz: branchTaken = ~aluLsb;
      condLtz:         branchTaken = lessThan;
      default:         branchTaken = ~lessThan;
    endcase
  end

  always_comb begin
    nextState = state;
    if (state == stateHalted) begin
      nextState = run ? stateFetch : stateHalted;
    end else if (pcIsZero) begin
      nextState = stateHalted;
    end else begin
      case (state)
        stateFetch, stateMemWait: nextState = waitrequest ? stateMemWait : stateDecode;
        stateDecode: nextState = stateExec1;
        stateExec1: begin
          if (!stall) nextState = needExec2 ? stateExec2 : stateFetch;
        end
        stateExec2: begin
          if (!waitrequest) nextState = (instrClass == classLoad) ? stateExec3 : stateFetch;
        end
        stateExec3: nextState = stateFetch;
        default:    nextState = stateHalted;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state       <= stateHalted;
      branchDelay <= 1'b0;
    end else begin
      state <= nextState;
      // Fetch consumes the flag, exec1 sets it for the next fetch
      if (state == stateFetch) begin
        branchDelay <= 1'b0;
      end else if (state == stateExec1) begin
        if (instrClass == classBranch) branchDelay <= branchTaken;
        else branchDelay <= instrClass inside {classJump, classJumpLink, classJumpReg};
      end
    end
  end

  assign pcWrite = (state == stateFetch);
  assign irWrite = (state == stateDecode);
  assign pcSrc   = (state == stateFetch) && branchDelay;
  assign active  = (state != stateHalted);

endmodule

`default_nettype wire

// File: design/datapathControl.sv
`timescale 1ns/100ps
`default_nettype none

module datapathControl (
  input  mipsCtrlPkg::ctrlState_t  state,
  input  mipsCtrlPkg::instrClass_t instrClass,
  input  mipsCtrlPkg::branchCond_t branchCond,
  input  mipsCtrlPkg::aluOp_t      immAluOp,
  output logic                     aluSrcA,
  output mipsCtrlPkg::aluSrcB_t    aluSrcB,
  output mipsCtrlPkg::aluOp_t      aluOp,
  output logic                     aluSel,
  output logic                     extSel,
  output logic                     regDst,
  output logic                     memToReg,
  output logic                     regWrite,
  output logic                     link
);
  import mipsCtrlPkg::*;

  logic isJump;
  logic isAlu;

  assign isJump = instrClass inside {classJump, classJumpLink};
  assign isAlu  = instrClass inside {classAluReg, classAluImm};

  always_comb begin
    // PC + 4 unless a state says otherwise
    aluSrcA  = 1'b0;
    aluSrcB  = srcBFour;
    aluOp    = aluAdd;
    aluSel   = 1'b0;
    extSel   = 1'b0;
    regDst   = 1'b0;
    memToReg = 1'b0;
    regWrite = 1'b0;
    link     = 1'b0;
    case (state)
      stateDecode: begin
        aluSrcB = srcBImmShifted;
        extSel  = isJump;
        aluOp   = isJump ? aluPassB : aluBranchTarget;
      end
      stateExec1: begin
        case (instrClass)
          classLoad, classStore: begin
            aluSrcA = 1'b1;
            aluSrcB = srcBImm;
          end
          classAluReg: begin
            aluSrcA = 1'b1;
            aluSrcB = srcBReg;
            aluOp   = aluFunct;
          end
          classAluImm: begin
            aluSrcA = 1'b1;
            aluSrcB = srcBImm;
            aluOp   = immAluOp;
            // Logical immediates are zero extended
            extSel  = (immAluOp != aluAdd);
          end
          classBranch: begin
            aluSrcA = 1'b1;
            aluSrcB = srcBReg;
            aluSel  = 1'b1;
            case (branchCond)
              condEq, condNe: aluOp = aluCompareEq;
              condGtz:        aluOp = aluSetGtz;
              default:        aluOp = aluSetLez;
            endcase
          end
          classJump, classJumpLink: begin
            aluSrcB = srcBImmShifted;
            extSel  = 1'b1;
            aluOp   = aluJumpTarget;
            link    = (instrClass == classJumpLink);
          end
          classJumpReg: begin
            aluSrcA = 1'b1;
            aluOp   = aluPassA;
          end
          default: ;
        endcase
      end
      stateExec2: begin
        aluSel   = 1'b1;
        regWrite = isAlu;
        memToReg = isAlu;
        regDst   = (instrClass == classAluReg);
      end
      stateExec3: regWrite = (instrClass == classLoad);
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: design/memAccessControl.sv
`timescale 1ns/100ps
`default_nettype none

module memAccessControl (
  input  mipsCtrlPkg::ctrlState_t   state,
  input  mipsCtrlPkg::instrClass_t  instrClass,
  input  mipsCtrlPkg::accessSize_t  accessSize,
  input  wire logic                 signedLoad,
  output logic                      memRead,
  output logic                      memWrite,
  output logic                      iOrD,
  output logic [3:0]                byteEnable,
  output mipsCtrlPkg::loadExtend_t  loadExtend
);
  import mipsCtrlPkg::*;

  logic isLoad;
  logic dataAccess;

  assign isLoad     = (instrClass == classLoad);
  assign dataAccess = (state == stateExec2) && (isLoad || instrClass == classStore);

  assign memRead  = (state == stateFetch) || (state == stateMemWait) ||
                    (state == stateExec2 && isLoad);
  assign memWrite = (state == stateExec2) && (instrClass == classStore);
  assign iOrD     = dataAccess;

  always_comb begin
    byteEnable = 4'b1111;
    if (dataAccess) begin
      case (accessSize)
        sizeHalf: byteEnable = 4'b0011;
        sizeByte: byteEnable = 4'b0001;
        default:  byteEnable = 4'b1111;
      endcase
    end
  end

  always_comb begin
    loadExtend = extendNone;
    if (isLoad && signedLoad) begin
      loadExtend = (accessSize == sizeByte) ? extendSignByte : extendSignHalf;
    end
  end

endmodule

`default_nettype wire

// File: design/mipsControl.sv
`timescale 1ns/100ps
`default_nettype none

module mipsControl (
  input  wire logic                               clk,
  input  wire logic                               rstN,
  input  wire logic                               run,
  input  wire logic                               pcIsZero,
  input  wire logic                               waitrequest,
  input  wire logic                               stall,
  input  wire logic                               aluLsb,
  input  wire logic                               lessThan,
  input  wire logic [mipsCtrlPkg::instrWidth-1:0] instr,
  output mipsCtrlPkg::ctrlState_t                 state,
  output logic                                    pcWrite,
  output logic                                    irWrite,
  output logic                                    pcSrc,
  output logic                                    active,
  output logic                                    aluSrcA,
  output mipsCtrlPkg::aluSrcB_t                   aluSrcB,
  output mipsCtrlPkg::aluOp_t                     aluOp,
  output logic                                    aluSel,
  output logic                                    extSel,
  output logic                                    regDst,
  output logic                                    memToReg,
  output logic                                    regWrite,
  output logic                                    link,
  output logic                                    memRead,
  output logic                                    memWrite,
  output logic                                    iOrD,
  output logic [3:0]                              byteEnable,
  output mipsCtrlPkg::loadExtend_t                loadExtend
);
  import mipsCtrlPkg::*;

  instrClass_t instrClass;
  branchCond_t branchCond;
  accessSize_t accessSize;
  logic        signedLoad;
  aluOp_t      immAluOp;

  instrClassifier classifier (
    .instr, .instrClass, .branchCond, .accessSize, .signedLoad, .immAluOp
  );

  controlSequencer sequencer (
    .clk, .rstN, .run, .pcIsZero, .waitrequest, .stall, .aluLsb, .lessThan,
    .instrClass, .branchCond, .state, .pcWrite, .irWrite, .pcSrc, .active
  );

  datapathControl datapath (
    .state, .instrClass, .branchCond, .immAluOp, .aluSrcA, .aluSrcB, .aluOp,
    .aluSel, .extSel, .regDst, .memToReg, .regWrite, .link
  );

  // Memory strobes and byte lanes
  memAccessControl memAccess (
    .state, .instrClass, .accessSize, .signedLoad, .memRead, .memWrite, .iOrD,
    .byteEnable, .loadExtend
  );

endmodule

`default_nettype wire

// File: test/clockGen.sv
`timescale 1ns/100ps
`default_nettype none

module clockGen (
  output logic clk,
  output logic rstN
);

  // 4 ns period
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    rstN = 1'b0;
    repeat (5) @(posedge clk);
    #1 rstN = 1'b1;
  end

endmodule

`default_nettype wire

// File: test/mipsControl_assert.sv
`timescale 1ns/100ps
`default_nettype none

module sequencerChecks (
  input wire logic                    clk,
  input wire logic                    rstN,
  input wire mipsCtrlPkg::ctrlState_t state,
  input wire logic                    pcSrc,
  input wire logic                    memRead,
  input wire logic                    memWrite
);
  import mipsCtrlPkg::*;

  memExclusive: assert property (@(posedge clk) !(memRead && memWrite))
    else $error("memRead and memWrite high together");

  pcSrcOnlyInFetch: assert property (@(posedge clk) pcSrc |-> state == stateFetch)
    else $error("pcSrc high outside fetch");

  // Exec3 is only ever entered from exec2
  exec3AfterExec2: assert property (@(posedge clk) disable iff (!rstN)
    state != stateExec2 |=> state != stateExec3)
    else $error("exec3 entered from a state other than exec2");

  resetToHalted: assert property (@(posedge clk) !rstN |=> state == stateHalted)
    else $error("state not halted after reset");

endmodule

bind mipsControl sequencerChecks checks (
  .clk, .rstN, .state, .pcSrc, .memRead, .memWrite
);

`default_nettype wire

// File: test/mipsControlTb.sv
`timescale 1ns/100ps
`default_nettype none

module mipsControlTb;
  import mipsCtrlPkg::*;

  localparam int testCount     = 6;
  localparam int cyclesPerTest = 40;
  localparam int clkPeriodNs   = 4;

  logic        clk;
  logic        rstN;
  logic        run;
  logic        pcIsZero;
  logic        waitrequest;
  logic        stall;
  logic        aluLsb;
  logic        lessThan;
  logic [31:0] instr;
  ctrlState_t  state;
  logic        pcWrite;
  logic        irWrite;
  logic        pcSrc;
  logic        active;
  logic        aluSrcA;
  aluSrcB_t    aluSrcB;
  aluOp_t      aluOp;
  logic        aluSel;
  logic        extSel;
  logic        regDst;
  logic        memToReg;
  logic        regWrite;
  logic        link;
  logic        memRead;
  logic        memWrite;
  logic        iOrD;
  logic [3:0]  byteEnable;
  loadExtend_t loadExtend;

  logic [31:0] rngState = 32'h2f994e8d;
  int          errorCount = 0;
  int          checkCount = 0;
  string       testName;
  logic        expPcSrc;

  clockGen clocks (.clk, .rstN);

  mipsControl dut (
    .clk, .rstN, .run, .pcIsZero, .waitrequest, .stall, .aluLsb, .lessThan, .instr,
    .state, .pcWrite, .irWrite, .pcSrc, .active, .aluSrcA, .aluSrcB, .aluOp, .aluSel,
    .extSel, .regDst, .memToReg, .regWrite, .link, .memRead, .memWrite, .iOrD,
    .byteEnable, .loadExtend
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] nextRandom();
    rngState = xorshift32(rngState);
    return rngState;
  endfunction

  function automatic logic [4:0] randomReg();
    logic [31:0] r;
    r = nextRandom();
    return r[4:0];
  endfunction

  // Instruction word builders with random register and immediate fields
  function automatic logic [31:0] rWord(input functCode_t funct);
    logic [31:0] r;
    r = nextRandom();
    return {6'b000000, r[25:11], 5'b00000, funct};
  endfunction

  function automatic logic [31:0] iWord(input opcode_t op, input logic [4:0] rt);
    logic [31:0] r;
    r = nextRandom();
    return {op, r[25:21], rt, r[15:0]};
  endfunction

  function automatic logic [31:0] jWord(input opcode_t op);
    logic [31:0] r;
    r = nextRandom();
    return {op, r[25:0]};
  endfunction

  task automatic reportMismatch(input string what, input string expStr, input string actStr);
    errorCount++;
    $display("FAILED %s %s: expected %s, got %s", testName, what, expStr, actStr);
  endtask

  task automatic checkState(input ctrlState_t exp, input ctrlState_t act);
    checkCount++;
    if (act !== exp) reportMismatch("state", exp.name(), act.name());
  endtask

  task automatic checkAluOp(input aluOp_t exp, input aluOp_t act);
    checkCount++;
    if (act !== exp) reportMismatch("aluOp", exp.name(), act.name());
  endtask

  task automatic checkSrcB(input aluSrcB_t exp, input aluSrcB_t act);
    checkCount++;
    if (act !== exp) reportMismatch("aluSrcB", exp.name(), act.name());
  endtask

  task automatic checkBit(input string what, input logic exp, input logic act);
    checkCount++;
    if (act !== exp) reportMismatch(what, $sformatf("%b", exp), $sformatf("%b", act));
  endtask

  task automatic checkByteEnable(input logic [3:0] exp, input logic [3:0] act);
    checkCount++;
    if (act !== exp) reportMismatch("byteEnable", $sformatf("%b", exp), $sformatf("%b", act));
  endtask

  task automatic checkExtend(input loadExtend_t exp, input loadExtend_t act);
    checkCount++;
    if (act !== exp) reportMismatch("loadExtend", exp.name(), act.name());
  endtask

  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic finishTest(input int errorsBefore);
    if (errorCount == errorsBefore) $display("%s: ok", testName);
    else $display("%s: %0d errors", testName, errorCount - errorsBefore);
  endtask

  // Entered 1 ns after the edge into fetch, left the same way
  task automatic runInstr(input logic [31:0] word, input instrClass_t cls,
                          input aluOp_t exec1Op, input logic [3:0] dataBe,
                          input loadExtend_t ext, input int fetchWait,
                          input int stallCycles, input int dataWait, input logic flag);
    int       i;
    int       execStates;
    logic     isAlu;
    logic     isLoad;
    logic     isStore;
    logic     isJump;
    logic     logicImm;
    aluOp_t   decodeOp;
    aluSrcB_t exec1SrcB;
    isAlu    = (cls == classAluReg) || (cls == classAluImm);
    isLoad   = (cls == classLoad);
    isStore  = (cls == classStore);
    isJump   = (cls == classJump) || (cls == classJumpLink);
    // Logical immediates take a zero extended operand
    logicImm = word[31:26] inside {opAndi, opOri, opXori};
    decodeOp = aluBranchTarget;
    if (isJump) decodeOp = aluPassB;
    exec1SrcB = srcBReg;
    if (isLoad || isStore || cls == classAluImm) exec1SrcB = srcBImm;
    if (isJump) exec1SrcB = srcBImmShifted;
    execStates = isLoad ? 3 : ((isAlu || isStore) ? 2 : 1);

    instr = word;
    waitrequest = (fetchWait > 0);
    #1;
    checkState(stateFetch, state);
    checkBit("pcWrite", 1'b1, pcWrite);
    checkBit("memRead", 1'b1, memRead);
    checkBit("pcSrc", expPcSrc, pcSrc);
    checkAluOp(aluAdd, aluOp);
    checkBit("aluSrcA", 1'b0, aluSrcA);
    checkSrcB(srcBFour, aluSrcB);
    for (i = 0; i < fetchWait; i++) begin
      tick();
      waitrequest = (i + 1 < fetchWait);
      #1;
      checkState(stateMemWait, state);
      checkBit("memRead", 1'b1, memRead);
      checkBit("pcWrite", 1'b0, pcWrite);
    end

    tick();
    #1;
    checkState(stateDecode, state);
    checkBit("irWrite", 1'b1, irWrite);
    checkBit("pcSrc", 1'b0, pcSrc);
    checkAluOp(decodeOp, aluOp);
    checkSrcB(srcBImmShifted, aluSrcB);
    checkBit("extSel", isJump, extSel);

    for (i = 0; i <= stallCycles; i++) begin
      tick();
      stall = (i < stallCycles);
      #1;
      checkState(stateExec1, state);
      checkAluOp(exec1Op, aluOp);
      checkBit("aluSrcA", !isJump, aluSrcA);
      if (cls != classJumpReg) checkSrcB(exec1SrcB, aluSrcB);
      checkBit("aluSel", cls == classBranch, aluSel);
      checkBit("extSel", isJump || logicImm, extSel);
      checkBit("link", cls == classJumpLink, link);
      checkBit("regWrite", 1'b0, regWrite);
      checkBit("memWrite", 1'b0, memWrite);
    end

    if (execStates >= 2) begin
      for (i = 0; i <= dataWait; i++) begin
        tick();
        waitrequest = (i < dataWait);
        #1;
        checkState(stateExec2, state);
        checkBit("aluSel", 1'b1, aluSel);
        checkBit("regWrite", isAlu, regWrite);
        checkBit("memToReg", isAlu, memToReg);
        checkBit("memRead", isLoad, memRead);
        checkBit("memWrite", isStore, memWrite);
        checkBit("iOrD", isLoad || isStore, iOrD);
        checkByteEnable(dataBe, byteEnable);
        checkExtend(ext, loadExtend);
        if (isAlu) checkBit("regDst", cls == classAluReg, regDst);
      end
    end

    if (execStates == 3) begin
      tick();
      #1;
      checkState(stateExec3, state);
      checkBit("regWrite", 1'b1, regWrite);
      checkBit("regDst", 1'b0, regDst);
      checkBit("memToReg", 1'b0, memToReg);
      checkBit("memRead", 1'b0, memRead);
    end
    tick();
    expPcSrc = flag;
  endtask

  task automatic resetRunTest();
    int errorsBefore;
    errorsBefore = errorCount;
    testName = "resetRun";
    #1;
    checkState(stateHalted, state);
    checkBit("active", 1'b0, active);
    checkBit("pcWrite", 1'b0, pcWrite);
    checkBit("irWrite", 1'b0, irWrite);
    checkBit("memRead", 1'b0, memRead);
    checkBit("memWrite", 1'b0, memWrite);
    checkBit("regWrite", 1'b0, regWrite);
    checkBit("link", 1'b0, link);
    tick();
    run = 1'b1;
    #1;
    checkState(stateHalted, state);
    tick();
    run = 1'b0;
    pcIsZero = 1'b1;
    #1;
    checkState(stateFetch, state);
    checkBit("active", 1'b1, active);
    tick();
    pcIsZero = 1'b0;
    #1;
    checkState(stateHalted, state);
    checkBit("active", 1'b0, active);
    tick();
    run = 1'b1;
    tick();
    run = 1'b0;
    expPcSrc = 1'b0;
    finishTest(errorsBefore);
  endtask

  task automatic aluTest();
    int errorsBefore;
    errorsBefore = errorCount;
    testName = "aluOps";
    runInstr(rWord(functAddu), classAluReg, aluFunct, 4'b1111, extendNone, 0, 0, 0, 1'b0);
    runInstr(rWord(functAnd), classAluReg, aluFunct, 4'b1111, extendNone, 0, 0, 0, 1'b0);
    runInstr(rWord(functOr), classAluReg, aluFunct, 4'b1111, extendNone, 0, 0, 0, 1'b0);
    runInstr(iWord(opAddiu, randomReg()), classAluImm, aluAdd, 4'b1111, extendNone,
             0, 0, 0, 1'b0);
    runInstr(iWord(opAndi, randomReg()), classAluImm, aluAnd, 4'b1111, extendNone,
             0, 0, 0, 1'b0);
    runInstr(iWord(opOri, randomReg()), classAluImm, aluOr, 4'b1111, extendNone,
             0, 0, 0, 1'b0);
    runInstr(iWord(opXori, randomReg()), classAluImm, aluXor, 4'b1111, extendNone,
             0, 0, 0, 1'b0);
    finishTest(errorsBefore);
  endtask

  task automatic loadTest();
    int errorsBefore;
    errorsBefore = errorCount;
    testName = "loads";
    runInstr(iWord(opLw, randomReg()), classLoad, aluAdd, 4'b1111, extendNone, 0, 0, 0, 1'b0);
    runInstr(iWord(opLh, randomReg()), classLoad, aluAdd, 4'b0011, extendSignHalf,
             0, 0, 0, 1'b0);
    runInstr(iWord(opLhu, randomReg()), classLoad, aluAdd, 4'b0011, extendNone, 0, 0, 0, 1'b0);
    runInstr(iWord(opLb, randomReg()), classLoad, aluAdd, 4'b0001, extendSignByte,
             0, 0, 0, 1'b0);
    runInstr(iWord(opLbu, randomReg()), classLoad, aluAdd, 4'b0001, extendNone, 0, 0, 0, 1'b0);
    // Memory wait on both the fetch and the data read
    runInstr(iWord(opLh, randomReg()), classLoad, aluAdd, 4'b0011, extendSignHalf,
             2, 0, 3, 1'b0);
    finishTest(errorsBefore);
  endtask

  task automatic storeTest();
    int errorsBefore;
    errorsBefore = errorCount;
    testName = "stores";
    runInstr(iWord(opSw, randomReg()), classStore, aluAdd, 4'b1111, extendNone, 0, 0, 0, 1'b0);
    runInstr(iWord(opSw, randomReg()), classStore, aluAdd, 4'b1111, extendNone, 0, 3, 0, 1'b0);
    finishTest(errorsBefore);
  endtask

  task automatic branchTest();
    int          errorsBefore;
    int          k;
    logic [31:0] r;
    logic [31:0] word;
    logic        taken;
    aluOp_t      cmpOp;
    errorsBefore = errorCount;
    testName = "branches";
    for (k = 0; k < 12; k++) begin
      r = nextRandom();
      aluLsb = r[0];
      lessThan = r[1];
      case (k % 6)
        0: word = iWord(opBeq, randomReg());
        1: word = iWord(opBne, randomReg());
        2: word = iWord(opBlez, 5'b00000);
        3: word = iWord(opBgtz, 5'b00000);
        4: word = iWord(opRegImm, 5'b00000);
        default: word = iWord(opRegImm, 5'b00001);
      endcase
      // Taken rule per condition
      case (k % 6)
        0, 2: taken = aluLsb;
        1, 3: taken = ~aluLsb;
        4: taken = lessThan;
        default: taken = ~lessThan;
      endcase
      case (k % 6)
        0, 1: cmpOp = aluCompareEq;
        3: cmpOp = aluSetGtz;
        default: cmpOp = aluSetLez;
      endcase
      runInstr(word, classBranch, cmpOp, 4'b1111, extendNone, 0, 0, 0, taken);
    end
    finishTest(errorsBefore);
  endtask

  task automatic jumpTest();
    int errorsBefore;
    errorsBefore = errorCount;
    testName = "jumps";
    runInstr(jWord(opJ), classJump, aluJumpTarget, 4'b1111, extendNone, 0, 0, 0, 1'b1);
    runInstr(jWord(opJal), classJumpLink, aluJumpTarget, 4'b1111, extendNone, 0, 0, 0, 1'b1);
    runInstr(rWord(functJr), classJumpReg, aluPassA, 4'b1111, extendNone, 0, 0, 0, 1'b1);
    // Fetch after the last jump takes the target
    #1;
    checkState(stateFetch, state);
    checkBit("pcSrc", expPcSrc, pcSrc);
    finishTest(errorsBefore);
  endtask

  initial begin
    run = 1'b0;
    pcIsZero = 1'b0;
    waitrequest = 1'b0;
    stall = 1'b0;
    aluLsb = 1'b0;
    lessThan = 1'b0;
    instr = 32'h0;
    expPcSrc = 1'b0;
    wait (rstN === 1'b1);
    resetRunTest();
    aluTest();
    loadTest();
    storeTest();
    branchTest();
    jumpTest();
    $display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(testCount * cyclesPerTest * clkPeriodNs);
    $display("timeout: the tests did not finish in time");
    $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

// File: mipsControl.f
design/mipsCtrlPkg.sv
design/instrClassifier.sv
design/controlSequencer.sv
design/datapathControl.sv
design/memAccessControl.sv
design/mipsControl.sv
test/clockGen.sv
test/mipsControl_assert.sv
test/mipsControlTb.sv

// File: run.sh
#!/bin/sh
# Build and run the mipsControl testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module mipsControlTb -f mipsControl.f -o simv
out=$(./obj_dir/simv) || true
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx '=== PASS ==='
